/* sim.f */
+incdir+rtl
rtl/riscv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_regfile.sv
rtl/rv_csr.sv
rtl/rv_execute.sv
rtl/riscv64.sv
sim/riscv64_chk.sv
sim/riscv64_monitor.sv
sim/tb_riscv64.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run with verilator, status follows the testbench verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_riscv64 -f sim.f -o tb_riscv64_sim \
    && ./obj_dir/tb_riscv64_sim +verilator+error+limit+100 | tee /dev/stderr \
    | grep -q "Simulation finished: PASS" \
    && echo "run_sim: passed" || { echo "run_sim: failed"; exit 1; }

/* sim/tb_riscv64.sv */
`timescale 1ns/1ps
`include "riscv_config.svh"

module tb_riscv64;

    localparam int run_cycles     = 2000;
    localparam int timeout_cycles = run_cycles + run_cycles / 2;  // reset plus margin
    localparam int rom_words      = 256;

    logic                clk;
    logic                reset;
    riscv_pkg::inst_t    instruction;
    logic [3:0]          interrupt_vector;
    riscv_pkg::xlen_t    bus_read_data;
    riscv_pkg::addr_t    pc;
    riscv_pkg::inst_t    ir;
    logic                heartbeat;
    logic                interrupt_ack;
    riscv_pkg::bus_req_t bus;

    logic [31:0]         rng_state;
    riscv_pkg::inst_t    rom [rom_words];  // program indexed by pc word
    int unsigned         cycle_count;
    int unsigned         error_total;

    riscv64 i_riscv64 (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .interrupt_vector (interrupt_vector),
        .bus_read_data    (bus_read_data),
        .pc               (pc),
        .ir               (ir),
        .heartbeat        (heartbeat),
        .interrupt_ack    (interrupt_ack),
        .bus              (bus)
    );

    riscv64_monitor i_monitor (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .interrupt_vector (interrupt_vector),
        .bus_read_data    (bus_read_data),
        .pc               (pc),
        .ir               (ir),
        .heartbeat        (heartbeat),
        .interrupt_ack    (interrupt_ack),
        .bus              (bus),
        .assert_fails     (i_riscv64.i_chk.fail_count),
        .error_total      (error_total)
    );

    bind riscv64 riscv64_chk i_chk (
        .clk           (clk),
        .reset         (reset),
        .bus           (bus),
        .pc            (pc),
        .interrupt_ack (interrupt_ack),
        .mcause        (i_csr.mcause)
    );

    always #10 clk = ~clk;  // 20 ns period

    function automatic logic [31:0] next_rand();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    // mix of lui, load, store, mret and plain no-ops
    function automatic riscv_pkg::inst_t random_instruction();
        logic [31:0] r;
        logic [4:0]  rd;
        r  = next_rand();
        rd = r[8] ? 5'd5 : r[13:9];  // x5 half the time to feed stores
        if (r[4:0] < 5'd10) begin
            return {r[31:12], rd, `OPC_LUI};
        end else if (r[4:0] < 5'd14) begin
            return `OP_LOAD;
        end else if (r[4:0] < 5'd19) begin
            return `OP_STORE;
        end else if (r[4:0] == 5'd19) begin
            return `OP_MRET;
        end
        return {r[31:7], 7'b001_0011};  // addi opcode acts as a no-op
    endfunction

    // mostly idle with line 1 or another value now and then
    function automatic logic [3:0] random_irq_level();
        logic [31:0] r;
        r = next_rand();
        if (r[3:0] == 4'd0) begin
            return 4'd1;
        end else if (r[3:0] == 4'd1) begin
            return r[7:4];
        end
        return 4'd0;
    endfunction

    // rom, irq source and key device driven on the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            instruction      <= 32'h0000_0001;
            interrupt_vector <= 4'd0;
        end else begin
            instruction      <= rom[pc[9:2]];
            interrupt_vector <= random_irq_level();
        end
        if (bus.re) begin
            bus_read_data <= {next_rand(), next_rand()};  // lands when the load completes
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            i_monitor.print_summary();
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rng_state        = 32'h8f73_e807;
        clk              = 1'b0;
        reset            = 1'b0;
        instruction      = 32'h0000_0001;
        interrupt_vector = 4'd0;
        bus_read_data    = '0;
        cycle_count      = 0;
        for (int i = 0; i < rom_words; i++) begin
            rom[i] = random_instruction();
        end
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        repeat (run_cycles) @(posedge clk);
        i_monitor.print_summary();
        if (error_total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* sim/riscv64_monitor.sv */
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv64_monitor (
    input  logic                clk,
    input  logic                reset,
    input  riscv_pkg::inst_t    instruction,
    input  logic [3:0]          interrupt_vector,
    input  riscv_pkg::xlen_t    bus_read_data,
    input  riscv_pkg::addr_t    pc,
    input  riscv_pkg::inst_t    ir,
    input  logic                heartbeat,
    input  logic                interrupt_ack,
    input  riscv_pkg::bus_req_t bus,
    input  int unsigned         assert_fails,   // from the bound checker
    output int unsigned         error_total
);

    localparam riscv_pkg::bus_req_t bus_idle = '{
        addr:  `RAM_BASE,
        wdata: '0,
        we:    1'b0,
        re:    1'b0
    };

    // architectural model
    riscv_pkg::exec_state_t m_state;
    riscv_pkg::addr_t       m_pc;
    riscv_pkg::addr_t       m_mepc;
    riscv_pkg::addr_t       next_pc;
    riscv_pkg::inst_t       m_ir;      // own copy of the fetch register
    riscv_pkg::xlen_t       m_regs [32];
    riscv_pkg::bus_req_t    m_bus;     // request expected after the edge
    logic                   m_ack;
    logic                   m_hb;      // expected heartbeat level
    logic                   m_mie;
    logic                   m_mpie;
    logic                   m_sent;    // load bubble already spent
    logic                   irq;

    int unsigned checks = 0;
    int unsigned irqs = 0;
    int unsigned stores = 0;
    int unsigned pc_errs = 0;
    int unsigned bus_errs = 0;
    int unsigned ack_errs = 0;
    int unsigned ir_errs = 0;
    int unsigned hb_errs = 0;

    assign error_total = pc_errs + bus_errs + ack_errs + ir_errs + hb_errs + assert_fails;

    // one step per rising edge on pre-edge input values
    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            m_state = riscv_pkg::run;
            m_pc    = `RAM_BASE;
            m_mepc  = '0;
            m_ir    = 32'h0000_0001;  // no-op out of reset
            m_bus   = bus_idle;
            m_ack   = 1'b0;
            m_hb    = 1'b0;
            m_mie   = 1'b1;
            m_mpie  = 1'b0;
            m_sent  = 1'b0;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = '0;
            end
        end else begin
            irq     = (interrupt_vector == 4'd1) && m_mie;
            m_ack   = irq;
            m_hb    = !m_hb;  // flips every clock
            m_bus   = bus_idle;
            next_pc = m_pc + 64'd4;
            if (irq) begin  // wins over flush and load wait
                irqs++;
                m_mepc  = m_pc;
                m_mpie  = m_mie;
                m_mie   = 1'b0;
                m_sent  = 1'b0;
                m_state = riscv_pkg::flush;
                next_pc = `TRAP_BASE;
            end else if (m_state == riscv_pkg::flush) begin
                m_state = riscv_pkg::run;  // stale ir is dropped
            end else if (m_state == riscv_pkg::load_wait) begin
                if (m_sent) begin
                    m_regs[5] = bus_read_data;  // key word into x5
                    m_state   = riscv_pkg::run;
                end
                m_sent = !m_sent;
            end else if (m_ir == `OP_MRET) begin
                next_pc = m_mepc;
                m_mie   = m_mpie;
                m_mpie  = 1'b1;
                m_state = riscv_pkg::flush;
            end else if (m_ir == `OP_LOAD) begin
                m_bus.addr = `KEY_BASE;
                m_bus.re   = 1'b1;
                next_pc    = m_pc - 64'd4;  // held back for the refetch
                m_state    = riscv_pkg::load_wait;
            end else if (m_ir == `OP_STORE) begin
                stores++;
                m_bus.addr  = `ART_BASE;
                m_bus.wdata = m_regs[5];
                m_bus.we    = 1'b1;
            end else if (m_ir[6:0] == `OPC_LUI && m_ir[11:7] != 5'd0) begin
                // upper immediate sign extended to 64 bits
                m_regs[m_ir[11:7]] = $signed({m_ir[31:12], 12'h000});
            end
            m_pc = next_pc;
            m_ir = instruction;  // fetch is one cycle behind
        end
    end

    function automatic int unsigned compare_value(string test, logic [63:0] expected,
                                                  logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s at %0t: expected %h, actual %h", test, $time, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        checks++;
        pc_errs  += compare_value("pc_sequence", m_pc, pc);
        bus_errs += compare_value("bus_addr", m_bus.addr, bus.addr);
        bus_errs += compare_value("bus_wdata", m_bus.wdata, bus.wdata);
        bus_errs += compare_value("bus_strobes", {62'd0, m_bus.we, m_bus.re},
                                  {62'd0, bus.we, bus.re});
        ack_errs += compare_value("interrupt_ack", {63'd0, m_ack}, {63'd0, interrupt_ack});
        ir_errs  += compare_value("fetch_ir", {32'd0, m_ir}, {32'd0, ir});
        hb_errs  += compare_value("heartbeat", {63'd0, m_hb}, {63'd0, heartbeat});
    end

    task automatic print_summary();
        string counts;
        counts = $sformatf("errors pc %0d bus %0d ack %0d ir %0d hb %0d assert %0d",
                           pc_errs, bus_errs, ack_errs, ir_errs, hb_errs, assert_fails);
        $display("checks %0d irqs %0d stores %0d, %s", checks, irqs, stores, counts);
    endtask

endmodule

/* sim/riscv64_chk.sv */
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv64_chk (
    input logic                clk,
    input logic                reset,
    input riscv_pkg::bus_req_t bus,
    input riscv_pkg::addr_t    pc,
    input logic                interrupt_ack,
    input riscv_pkg::xlen_t    mcause         // csr unit, reached through the bind
);

    int unsigned fail_count = 0;  // read back by the testbench

    // one device access per cycle
    strobe_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(bus.re && bus.we))
        else begin
            $error("read and write strobes are high in the same cycle");
            fail_count++;
        end

    // MIE drops on entry, so no back to back ack
    ack_single_cycle: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> !interrupt_ack)
        else begin
            $error("interrupt_ack stayed high for more than one cycle");
            fail_count++;
        end

    ack_at_trap_base: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |-> (pc == `TRAP_BASE))
        else begin
            $error("pc is not at the trap base while interrupt_ack is high");
            fail_count++;
        end

    ack_sets_mcause: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |-> mcause[63])
        else begin
            $error("mcause interrupt bit is clear after an ack");
            fail_count++;
        end

endmodule

/* rtl/riscv64.sv */
`timescale 1ns/1ps

module riscv64 (
    input  logic                  clk,
    input  logic                  reset,             // active low
    input  riscv_pkg::inst_t      instruction,       // from rom model
    input  logic [3:0]            interrupt_vector,  // level from outside
    input  riscv_pkg::xlen_t      bus_read_data,
    output riscv_pkg::addr_t      pc,
    output riscv_pkg::inst_t      ir,
    output logic                  heartbeat,
    output logic                  interrupt_ack,     // one cycle pulse
    output riscv_pkg::bus_req_t   bus
);

    riscv_pkg::rf_write_t rf_wr;
    riscv_pkg::reg_idx_t  rf_rd_idx;
    riscv_pkg::xlen_t     rf_rd_data;
    riscv_pkg::trap_cmd_t trap;
    riscv_pkg::addr_t     mepc;
    logic                 irq_enabled;

    // instruction register
    rv_fetch i_fetch (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .ir          (ir),
        .heartbeat   (heartbeat)
    );

    // pc, decode, bus
    rv_execute i_execute (
        .clk              (clk),
        .reset            (reset),
        .ir               (ir),
        .interrupt_vector (interrupt_vector),
        .irq_enabled      (irq_enabled),
        .mepc             (mepc),
        .rf_rd_data       (rf_rd_data),
        .bus_read_data    (bus_read_data),
        .pc               (pc),
        .bus              (bus),
        .interrupt_ack    (interrupt_ack),
        .rf_wr            (rf_wr),
        .rf_rd_idx        (rf_rd_idx),
        .trap             (trap)
    );

    // trap state
    rv_csr i_csr (
        .clk         (clk),
        .reset       (reset),
        .cmd         (trap),
        .irq_enabled (irq_enabled),
        .mepc        (mepc)
    );

    // x0..x31
    rv_regfile i_regfile (
        .clk     (clk),
        .reset   (reset),
        .wr      (rf_wr),
        .rd_idx  (rf_rd_idx),
        .rd_data (rf_rd_data)
    );

endmodule

/* rtl/rv_execute.sv */
`timescale 1ns/1ps
`include "riscv_config.svh"

module rv_execute (
    input  logic                   clk,
    input  logic                   reset,
    input  riscv_pkg::inst_t       ir,
    input  logic [3:0]             interrupt_vector,
    input  logic                   irq_enabled,    // mstatus.MIE
    input  riscv_pkg::addr_t       mepc,
    input  riscv_pkg::xlen_t       rf_rd_data,     // x5 value
    input  riscv_pkg::xlen_t       bus_read_data,
    output riscv_pkg::addr_t       pc,
    output riscv_pkg::bus_req_t    bus,
    output logic                   interrupt_ack,
    output riscv_pkg::rf_write_t   rf_wr,
    output riscv_pkg::reg_idx_t    rf_rd_idx,
    output riscv_pkg::trap_cmd_t   trap
);

    // load target and store source
    localparam riscv_pkg::reg_idx_t io_reg = 5'd5;

    riscv_pkg::exec_state_t state;
    logic                   load_sent;  // second visit of the load in load_wait

    logic             irq_fire;
    logic             exec_run;   // ir is live and decoded this cycle
    logic             load_done;  // refetched load reaches ir
    logic             is_lui;
    logic             is_load;
    logic             is_store;
    logic             is_mret;
    riscv_pkg::xlen_t imm_u;

    // idle bus: ram base, no strobes
    localparam riscv_pkg::bus_req_t bus_idle = '{
        addr:  `RAM_BASE,
        wdata: '0,
        we:    1'b0,
        re:    1'b0
    };

    // interrupt beats everything, including flush cycles
    assign irq_fire = (interrupt_vector == 4'd1) && irq_enabled;

    assign exec_run  = !irq_fire && (state == riscv_pkg::run);
    assign load_done = !irq_fire && (state == riscv_pkg::load_wait) && load_sent;

    // decode
    assign is_lui   = (ir[6:0] == `OPC_LUI);
    assign is_load  = (ir == `OP_LOAD);
    assign is_store = (ir == `OP_STORE);
    assign is_mret  = (ir == `OP_MRET);
    assign imm_u    = {{32{ir[31]}}, ir[31:12], 12'b0};  // sign-extended upper imm

    assign rf_rd_idx = io_reg;  // store only ever reads x5

    // trap commands, applied by the csr unit on this edge
    // take_irq drops by itself since MIE clears on entry
    always_comb begin
        trap.take_irq = irq_fire;
        trap.do_mret  = exec_run && is_mret;
        trap.pc       = pc;  // saved as mepc
    end

    // register writes: lui or load completion
    always_comb begin
        rf_wr = '0;
        if (exec_run && is_lui) begin
            rf_wr.en   = 1'b1;
            rf_wr.idx  = ir[11:7];
            rf_wr.data = imm_u;
        end else if (load_done) begin
            rf_wr.en   = 1'b1;
            rf_wr.idx  = io_reg;
            rf_wr.data = bus_read_data;  // key word, two cycles after re
        end
    end

    // pc, state, bus strobes, ack
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state         <= riscv_pkg::run;
            load_sent     <= 1'b0;
            pc            <= `RAM_BASE;
            bus           <= bus_idle;
            interrupt_ack <= 1'b0;
        end else begin
            pc            <= pc + 64'd4;  // default advance
            bus           <= bus_idle;    // strobes last one cycle
            interrupt_ack <= irq_fire;
            if (irq_fire) begin
                pc        <= `TRAP_BASE;
                state     <= riscv_pkg::flush;  // ir after this is stale
                load_sent <= 1'b0;              // pending load abandoned
            end else begin
                case (state)
                    riscv_pkg::flush: begin
                        state <= riscv_pkg::run;  // ir ignored
                    end
                    riscv_pkg::load_wait: begin
                        if (!load_sent) begin
                            load_sent <= 1'b1;  // bubble, read in flight
                        end else begin
                            load_sent <= 1'b0;  // x5 written this edge
                            state     <= riscv_pkg::run;
                        end
                    end
                    default: begin
                        if (is_mret) begin
                            pc    <= mepc;
                            state <= riscv_pkg::flush;
                        end else if (is_load) begin
                            bus.addr <= `KEY_BASE;
                            bus.re   <= 1'b1;
                            pc       <= pc - 64'd4;  // step back, refetch the load
                            state    <= riscv_pkg::load_wait;
                        end else if (is_store) begin
                            bus.addr  <= `ART_BASE;
                            bus.wdata <= rf_rd_data;
                            bus.we    <= 1'b1;
                        end
                        // lui goes through rf_wr, rest are no-ops
                    end
                endcase
            end
        end
    end

endmodule

/* rtl/rv_csr.sv */
`timescale 1ns/1ps

module rv_csr (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::trap_cmd_t cmd,          // from execute
    output logic                 irq_enabled,  // mstatus.MIE
    output riscv_pkg::addr_t     mepc
);

    // interrupt bit set, cause 11 = machine external interrupt
    localparam riscv_pkg::xlen_t irq_cause = 64'h8000_0000_0000_000b;

    logic             mstatus_mie;
    logic             mstatus_mpie;
    riscv_pkg::xlen_t mcause;  // kept for a later csr read path

    assign irq_enabled = mstatus_mie;

    // mstatus bits
    // the interrupt condition is decided in execute; here only the
    // commands are applied
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_mie  <= 1'b1;  // interrupts on out of reset
            mstatus_mpie <= 1'b0;
        end else if (cmd.take_irq) begin
            mstatus_mpie <= mstatus_mie;  // stack the enable
            mstatus_mie  <= 1'b0;         // no nesting
        end else if (cmd.do_mret) begin
            mstatus_mie  <= mstatus_mpie; // pop
            mstatus_mpie <= 1'b1;
        end
    end

    // mepc, return point of the handler
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mepc <= '0;
        end else if (cmd.take_irq) begin
            mepc <= cmd.pc;  // pc of the instruction not yet run
        end
    end

    // mcause, only external irq can be recorded
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mcause <= '0;
        end else if (cmd.take_irq) begin
            mcause <= irq_cause;
        end
    end

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::rf_write_t wr,       // single write port
    input  riscv_pkg::reg_idx_t  rd_idx,   // single read port
    output riscv_pkg::xlen_t     rd_data
);

    riscv_pkg::xlen_t regs [32];

    // write on the edge that ends the cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.idx != '0) begin  // x0 stays zero
            regs[wr.idx] <= wr.data;
        end
    end

    // async read, so a write is seen the very next cycle
    always_comb begin
        if (rd_idx == '0) begin
            rd_data = '0;  // x0 hardwired
        end else begin
            rd_data = regs[rd_idx];
        end
    end

endmodule

/* rtl/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch (
    input  logic             clk,
    input  logic             reset,
    input  riscv_pkg::inst_t instruction,  // word from the rom side
    output riscv_pkg::inst_t ir,
    output logic             heartbeat
);

    // word 1 has no matching encoding, so it behaves as a no-op
    localparam riscv_pkg::inst_t nop_word = 32'h0000_0001;

    // instruction register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= nop_word;
        end else begin
            ir <= instruction;  // one cycle behind the fetch
        end
    end

    // liveness, flips every clock
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            heartbeat <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat;
        end
    end

endmodule

/* rtl/riscv_pkg.sv */
package riscv_pkg;

    // widths with a meaning
    typedef logic [63:0] xlen_t;     // register / data word
    typedef logic [63:0] addr_t;     // pc or bus address
    typedef logic [31:0] inst_t;     // instruction word
    typedef logic [4:0]  reg_idx_t;  // register index

    // execute stage control
    typedef enum logic [1:0] {
        run,        // normal decode
        flush,      // drop ir after a redirect
        load_wait   // refetch of the load, read in flight
    } exec_state_t;

    // one bus request, registered at the core boundary
    typedef struct packed {
        addr_t addr;
        xlen_t wdata;
        logic  we;   // one cycle write strobe
        logic  re;   // one cycle read strobe
    } bus_req_t;

    // register file write port
    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        xlen_t    data;
    } rf_write_t;

    // execute -> csr unit
    typedef struct packed {
        logic  take_irq;  // trap entry, single cycle
        logic  do_mret;   // trap return
        addr_t pc;        // pc to save on entry
    } trap_cmd_t;

endpackage

/* rtl/riscv_config.svh */
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// address map
`define RAM_BASE  64'h0000_0000_8000_0000  // reset pc, idle bus address
`define KEY_BASE  64'h0000_0000_1000_0000  // key device, load source
`define ART_BASE  64'h0000_0000_1000_1000  // display device, store target

// fixed mtvec, no csr writes in this core
`define TRAP_BASE 64'h0000_0000_8000_0100

// custom encodings
`define OP_LOAD   32'hffff_ffff  // all ones
`define OP_STORE  32'hffff_ff7f  // all ones, bit 7 clear
`define OP_MRET   32'h0000_0000  // all zeros

// standard major opcode
`define OPC_LUI   7'b011_0111

`endif
